//--- Bender.yml
package:
  name: credit_mux

sources:
  - rtl/credit_mux_pkg.sv
  - rtl/credit_rx_fifo.sv
  - rtl/packet_arbiter.sv
  - rtl/credit_tx.sv
  - rtl/credit_mux_top.sv
  - target: test
    files:
      - verification/credit_mux_assertions.sv
      - verification/tb_credit_mux.sv

//--- rtl/credit_mux_pkg.sv
// flit word types for the two-port credit link multiplexer
// header/payload union, link and stream structs, sizing constants

package credit_mux_pkg;

  // ----------------------------------------------------------------------
  // sizing
  // ----------------------------------------------------------------------

  // payload word width
  localparam int data_width = 16;
  // header length field, 0..15 payload flits per packet
  localparam int len_width = 4;
  // header source tag
  localparam int src_width = 4;
  // downstream credits granted after reset
  localparam int max_credits = 8;
  // credit counter width in the transmitter, must hold max_credits
  localparam int credit_width = $clog2(max_credits + 1);

  // ----------------------------------------------------------------------
  // flit word
  // ----------------------------------------------------------------------

  // header view of a flit word, src in the top bits
  typedef struct packed {
    logic [src_width-1:0]                        src;
    logic [len_width-1:0]                        len;
    logic [data_width-src_width-len_width-1:0]   spare;
  } hdr_fields_t;

  // same word, read as header fields or as raw payload
  typedef union packed {
    hdr_fields_t             hdr;
    logic [data_width-1:0]   raw;
  } flit_body_u;

  // is_hdr selects which view of body applies
  typedef struct packed {
    logic         is_hdr;
    flit_body_u   body;
  } flit_t;

  // ----------------------------------------------------------------------
  // link halves
  // ----------------------------------------------------------------------

  // forward half of a valid/credit link
  // credit return travels separately as cr
  typedef struct packed {
    logic    vld;
    flit_t   flit;
  } credit_link_t;

  // forward half of an srdy/drdy stream
  // drdy travels separately
  typedef struct packed {
    logic    srdy;
    flit_t   flit;
  } sd_stream_t;

endpackage

//--- rtl/credit_mux_top.sv
// two-port credit link multiplexer top level
// two receive FIFOs, packet arbiter, credit transmitter

`timescale 1ns/100ps

module credit_mux_top
  import credit_mux_pkg::*;
#(
  // receive FIFO depth per port, power of two
  parameter int depth = 8
)
(
  input  logic           clk,
  input  logic           reset,
  input  credit_link_t   in0_link,
  output logic           in0_cr,
  input  credit_link_t   in1_link,
  output logic           in1_cr,
  output credit_link_t   out_link,
  input  logic           out_cr
);

  // fifo to arbiter streams
  sd_stream_t   rx0_stream;
  sd_stream_t   rx1_stream;
  logic         rx0_drdy;
  logic         rx1_drdy;
  // arbiter to transmitter
  sd_stream_t   arb_stream;
  logic         arb_drdy;

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------

  credit_rx_fifo #(.depth(depth)) rx0 (
    .clk      (clk),
    .reset    (reset),
    .c_link   (in0_link),
    .c_cr     (in0_cr),
    .p_stream (rx0_stream),
    .p_drdy   (rx0_drdy)
  );

  credit_rx_fifo #(.depth(depth)) rx1 (
    .clk      (clk),
    .reset    (reset),
    .c_link   (in1_link),
    .c_cr     (in1_cr),
    .p_stream (rx1_stream),
    .p_drdy   (rx1_drdy)
  );

  // ----------------------------------------------------------------------
  // merge and output
  // ----------------------------------------------------------------------

  packet_arbiter arb (
    .clk      (clk),
    .reset    (reset),
    .in0      (rx0_stream),
    .in0_drdy (rx0_drdy),
    .in1      (rx1_stream),
    .in1_drdy (rx1_drdy),
    .out      (arb_stream),
    .out_drdy (arb_drdy)
  );

  credit_tx tx (
    .clk      (clk),
    .reset    (reset),
    .in       (arb_stream),
    .in_drdy  (arb_drdy),
    .out_link (out_link),
    .out_cr   (out_cr)
  );

endmodule

//--- rtl/credit_rx_fifo.sv
// valid/credit receive FIFO
// issues credits upstream, presents a registered srdy/drdy stream

`timescale 1ns/100ps

module credit_rx_fifo
  import credit_mux_pkg::*;
#(
  parameter int depth = 8
)
(
  input  logic           clk,
  input  logic           reset,
  input  credit_link_t   c_link,
  output logic           c_cr,
  output sd_stream_t     p_stream,
  input  logic           p_drdy
);

  // pointer index width, depth is a power of two
  localparam int asz = $clog2(depth);

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------

  // wrap-bit pointers
  logic [asz:0]     wrptr;
  logic [asz:0]     rdptr;
  logic [asz:0]     nxt_wrptr;
  logic [asz:0]     nxt_rdptr;
  // flits held, including the one sitting in the output register
  logic [asz:0]     usage;
  logic [asz:0]     nxt_usage;
  // credits handed out but not yet used by the sender
  logic [asz:0]     cissued;
  logic [asz:0]     nxt_cissued;
  // one extra bit so the sum never wraps
  logic [asz+1:0]   crtotal;
  logic             full;
  logic             wr_en;
  logic             rd_xfer;
  logic             nxt_p_srdy;
  logic             p_srdy;
  flit_t            p_flit;

  flit_t            buffer [depth];

  // ----------------------------------------------------------------------
  // credit and occupancy bookkeeping
  // ----------------------------------------------------------------------

  // in-flight credit on c_cr counts too
  assign crtotal = (asz + 2)'(usage) + (asz + 2)'(cissued) + (asz + 2)'(c_cr);

  // same index, opposite wrap bit
  assign full = (wrptr[asz-1:0] == rdptr[asz-1:0]) && (wrptr[asz] != rdptr[asz]);

  // sender obeys credits, full check is only a guard
  assign wr_en   = c_link.vld & ~full;
  assign rd_xfer = p_srdy & p_drdy;

  always_comb
  begin
    nxt_wrptr = wr_en ? wrptr + 1'b1 : wrptr;

    // credit out and flit in on the same cycle cancel
    if (c_cr & ~c_link.vld)
      nxt_cissued = cissued + 1'b1;
    else if (c_link.vld & ~c_cr)
      nxt_cissued = cissued - 1'b1;
    else
      nxt_cissued = cissued;

    if (c_link.vld & ~rd_xfer)
      nxt_usage = usage + 1'b1;
    else if (rd_xfer & ~c_link.vld)
      nxt_usage = usage - 1'b1;
    else
      nxt_usage = usage;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrptr   <= '0;
      cissued <= '0;
      usage   <= '0;
      c_cr    <= 1'b0;
    end
    else
    begin
      wrptr   <= nxt_wrptr;
      cissued <= nxt_cissued;
      usage   <= nxt_usage;
      // one credit per cycle while room remains
      c_cr    <= (crtotal < depth);
    end
  end

  // ----------------------------------------------------------------------
  // read side
  // ----------------------------------------------------------------------

  always_comb
  begin
    nxt_rdptr  = rd_xfer ? rdptr + 1'b1 : rdptr;
    // anything left after this cycle's read
    nxt_p_srdy = (nxt_wrptr != nxt_rdptr);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rdptr  <= '0;
      p_srdy <= 1'b0;
    end
    else
    begin
      rdptr  <= nxt_rdptr;
      p_srdy <= nxt_p_srdy;
    end
  end

  // storage
  always_ff @(posedge clk)
  begin
    if (wr_en)
      buffer[wrptr[asz-1:0]] <= c_link.flit;
  end

  // prefetch next head into the output register
  // a bypass covers the flit written on this same edge
  always_ff @(posedge clk)
  begin
    if (wr_en && (wrptr[asz-1:0] == nxt_rdptr[asz-1:0]))
      p_flit <= c_link.flit;
    else
      p_flit <= buffer[nxt_rdptr[asz-1:0]];
  end

  assign p_stream.srdy = p_srdy;
  assign p_stream.flit = p_flit;

endmodule

//--- rtl/credit_tx.sv
// srdy/drdy to valid/credit transmitter
// counts downstream credits, sends one flit per credit

`timescale 1ns/100ps

module credit_tx
  import credit_mux_pkg::*;
(
  input  logic           clk,
  input  logic           reset,
  input  sd_stream_t     in,
  output logic           in_drdy,
  output credit_link_t   out_link,
  input  logic           out_cr
);

  // ----------------------------------------------------------------------
  // credit counter
  // ----------------------------------------------------------------------

  // credits granted by the receiver, not yet spent
  logic [credit_width-1:0]   credits;
  logic                      xfer;
  logic                      out_vld;
  flit_t                     out_flit;

  // accept only with a credit in hand
  assign in_drdy = (credits != '0);
  assign xfer    = in.srdy & in_drdy;

  always_ff @(posedge clk)
  begin
    if (reset)
      credits <= '0;
    else if (out_cr & ~xfer)
      credits <= credits + 1'b1;
    else if (xfer & ~out_cr)
      credits <= credits - 1'b1;
    // return and send together, count unchanged
  end

  // ----------------------------------------------------------------------
  // output register
  // ----------------------------------------------------------------------

  // vld is a one-cycle pulse per accepted flit
  always_ff @(posedge clk)
  begin
    if (reset)
      out_vld <= 1'b0;
    else
      out_vld <= xfer;
  end

  // data only loads on accept
  always_ff @(posedge clk)
  begin
    if (xfer)
      out_flit <= in.flit;
  end

  assign out_link.vld  = out_vld;
  assign out_link.flit = out_flit;

endmodule

//--- rtl/packet_arbiter.sv
// two-input round-robin packet arbiter
// grant held from header until the last payload flit

`timescale 1ns/100ps

module packet_arbiter
  import credit_mux_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  sd_stream_t   in0,
  output logic         in0_drdy,
  input  sd_stream_t   in1,
  output logic         in1_drdy,
  output sd_stream_t   out,
  input  logic         out_drdy
);

  // ----------------------------------------------------------------------
  // state
  // ----------------------------------------------------------------------

  // priority pointer, moves only when a packet ends
  logic                   grant;
  // port that owns the packet in progress
  logic                   owner;
  // payload flits still owed, nonzero means locked
  logic [len_width-1:0]   remaining;

  logic                   busy;
  logic                   sel;
  logic                   idle_sel;
  sd_stream_t             sel_stream;
  logic                   xfer;
  logic                   last_flit;
  logic [len_width-1:0]   rem_left;

  assign busy = (remaining != '0);

  // ----------------------------------------------------------------------
  // port select
  // ----------------------------------------------------------------------

  always_comb
  begin
    // pointed-at port first, else the other one if it waits
    if (grant == 1'b0)
      idle_sel = (~in0.srdy & in1.srdy);
    else
      idle_sel = ~(~in1.srdy & in0.srdy);

    // locked ports stay put until the packet is done
    sel = busy ? owner : idle_sel;
    sel_stream = sel ? in1 : in0;
  end

  assign out      = sel_stream;
  assign xfer     = sel_stream.srdy & out_drdy;
  assign in0_drdy = out_drdy & (sel == 1'b0);
  assign in1_drdy = out_drdy & (sel == 1'b1);

  // ----------------------------------------------------------------------
  // packet tracking
  // ----------------------------------------------------------------------

  // header loads its length, payload counts down
  assign rem_left  = busy ? remaining - 1'b1 : sel_stream.flit.body.hdr.len;
  assign last_flit = xfer & (rem_left == '0);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      grant     <= 1'b0;
      owner     <= 1'b0;
      remaining <= '0;
    end
    else
    begin
      if (xfer)
        remaining <= rem_left;

      // lock onto the header's port
      if (xfer && !busy)
        owner <= sel;

      // next packet prefers the other port
      if (last_flit)
        grant <= ~sel;
    end
  end

endmodule

//--- verification/credit_mux_assertions.sv
// concurrent checks on the multiplexer's external links
// credit discipline on all three links, input credits low in reset

`timescale 1ns/100ps

module credit_mux_assertions
  import credit_mux_pkg::*;
(
  input logic           clk,
  input logic           reset,
  input credit_link_t   in0_link,
  input logic           in0_cr,
  input credit_link_t   in1_link,
  input logic           in1_cr,
  input credit_link_t   out_link,
  input logic           out_cr
);

  // assertion failures so far
  int     fail_count = 0;
  // credits each sender holds, cr pulses minus flits sent
  int     in0_held;
  int     in1_held;
  int     out_held;
  logic   reset_d;

  always_ff @(posedge clk)
  begin
    reset_d <= reset;
    if (reset)
    begin
      in0_held <= 0;
      in1_held <= 0;
      out_held <= 0;
    end
    else
    begin
      in0_held <= in0_held + int'(in0_cr) - int'(in0_link.vld);
      in1_held <= in1_held + int'(in1_cr) - int'(in1_link.vld);
      out_held <= out_held + int'(out_cr) - int'(out_link.vld);
    end
  end

  in0_credit: assert property (@(posedge clk) disable iff (reset) in0_link.vld |-> in0_held > 0)
    else
    begin
      $error("in0_link vld with no credit held");
      fail_count++;
    end

  in1_credit: assert property (@(posedge clk) disable iff (reset) in1_link.vld |-> in1_held > 0)
    else
    begin
      $error("in1_link vld with no credit held");
      fail_count++;
    end

  out_credit: assert property (@(posedge clk) disable iff (reset) out_link.vld |-> out_held > 0)
    else
    begin
      $error("out_link vld beyond credits returned on out_cr");
      fail_count++;
    end

  // from the second reset edge on, the registers are cleared
  reset_cr: assert property (@(posedge clk) reset && reset_d |-> !in0_cr && !in1_cr)
    else
    begin
      $error("input credit returned during reset");
      fail_count++;
    end

endmodule

bind credit_mux_top credit_mux_assertions chk (.*);

//--- verification/tb_credit_mux.sv
// testbench for the two-port credit link multiplexer
// random credit-obeying senders, downstream receiver model, scoreboard

`timescale 1ns/100ps

module tb_credit_mux
  import credit_mux_pkg::*;
();

  localparam int fifo_depth  = 8;
  localparam int num_packets = 300;

  // expected entry, flit plus the cycle it was sent in
  typedef struct packed {
    int      cyc;
    flit_t   flit;
  } exp_t;

  logic                 clk;
  logic                 reset;
  credit_link_t [1:0]   in_link;
  logic [1:0]           in_cr;
  credit_link_t         out_link;
  logic                 out_cr;

  int     cycle;
  // cr pulses seen per input, and flits sent per input
  int     cr_total [2];
  int     sent [2];
  exp_t   exp_q0 [$];
  exp_t   exp_q1 [$];
  // output side scoreboard
  int     rx_count;
  int     cr_given;
  int     pkt_src;
  int     pkt_left;
  int     last_src;
  int     stall_at;

  credit_mux_top #(.depth(fifo_depth)) dut (
    .clk      (clk),
    .reset    (reset),
    .in0_link (in_link[0]),
    .in0_cr   (in_cr[0]),
    .in1_link (in_link[1]),
    .in1_cr   (in_cr[1]),
    .out_link (out_link),
    .out_cr   (out_cr)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // failure reporting and compares
  // ----------------------------------------------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_flit(input string name, input flit_t exp, input flit_t act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_count(input string name, input logic [credit_width-1:0] exp,
                             input logic [credit_width-1:0] act);
    if (act !== exp)
      abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
  endtask

  // cycle count, input credits, and the progress watchdog
  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (!reset && in_cr[0])
      cr_total[0] <= cr_total[0] + 1;
    if (!reset && in_cr[1])
      cr_total[1] <= cr_total[1] + 1;
    // a bound link assertion has fired
    if (dut.chk.fail_count != 0)
      abort_run("a link assertion failed");
    // 200 cycles per flit sent, plus start-up slack
    if (cycle > 1000 + 200 * (sent[0] + sent[1]))
      abort_run("timeout: the run stopped making progress");
  end

  // ----------------------------------------------------------------------
  // senders
  // ----------------------------------------------------------------------

  task automatic push_expected(input int port, input flit_t f);
    exp_t e;
    e.cyc  = cycle;
    e.flit = f;
    if (port == 0)
      exp_q0.push_back(e);
    else
      exp_q1.push_back(e);
  endtask

  // cycles the oldest unreceived flit of a port has been in flight
  function automatic int oldest_wait(input int port);
    if (port == 0)
      return (exp_q0.size() == 0) ? 0 : cycle - exp_q0[0].cyc;
    return (exp_q1.size() == 0) ? 0 : cycle - exp_q1[0].cyc;
  endfunction

  task automatic send_flit(input int port, input flit_t f);
    credit_link_t l;
    bit           done;
    done = 1'b0;
    while (!done)
    begin
      @(posedge clk);
      if (cr_total[port] - sent[port] > fifo_depth)
        check_count($sformatf("in%0d_cr credits held", port), credit_width'(fifo_depth),
                    credit_width'(cr_total[port] - sent[port]));
      l.flit = f;
      l.vld  = 1'b0;
      // only with credit in hand, idle one cycle in four
      if (cr_total[port] - sent[port] > 0 && $urandom_range(3) != 0)
      begin
        l.vld = 1'b1;
        sent[port]++;
        push_expected(port, f);
        done = 1'b1;
      end
      in_link[port] <= l;
    end
  endtask

  task automatic run_sender(input int port);
    flit_t f;
    int    len;
    int    p;
    int    i;
    // startup credits, then none extra
    while (cr_total[port] - sent[port] < fifo_depth)
      @(posedge clk);
    repeat (3) @(posedge clk);
    check_count($sformatf("in%0d_cr credits after reset", port), credit_width'(fifo_depth),
                credit_width'(cr_total[port]));
    for (p = 0; p < num_packets; p++)
    begin
      len                = $urandom_range(15);
      f.is_hdr           = 1'b1;
      f.body.hdr.src     = src_width'(port);
      f.body.hdr.len     = len_width'(len);
      f.body.hdr.spare   = (data_width - src_width - len_width)'($urandom);
      send_flit(port, f);
      for (i = 0; i < len; i++)
      begin
        f.is_hdr   = 1'b0;
        f.body.raw = data_width'($urandom);
        send_flit(port, f);
      end
    end
    @(posedge clk);
    in_link[port] <= '0;
  endtask

  // ----------------------------------------------------------------------
  // downstream receiver and scoreboard
  // ----------------------------------------------------------------------

  task automatic score_flit(input flit_t f);
    exp_t e;
    if (pkt_left == 0)
    begin
      // new packet, source taken from its header
      if (!f.is_hdr)
        abort_run("payload flit on out_link outside any packet");
      if (f.body.hdr.src > 1)
        abort_run("header on out_link with an unknown source tag");
      pkt_src  = f.body.hdr.src;
      pkt_left = f.body.hdr.len;
      // other port's header was already at its FIFO head
      if (pkt_src == last_src && oldest_wait(1 - pkt_src) >= 4)
        abort_run("arbiter granted one port twice while the other waited");
      last_src = pkt_src;
    end
    else
      pkt_left--;
    if ((pkt_src == 0 && exp_q0.size() == 0) || (pkt_src == 1 && exp_q1.size() == 0))
      abort_run("flit on out_link with nothing expected from its source");
    if (pkt_src == 0)
      e = exp_q0.pop_front();
    else
      e = exp_q1.pop_front();
    check_flit("out_link.flit", e.flit, f);
  endtask

  task automatic run_receiver();
    int owed;
    int stall_left;
    // initial grant of max_credits
    owed       = max_credits;
    stall_left = 0;
    forever
    begin
      @(posedge clk);
      if (out_link.vld)
      begin
        if (sent[0] + sent[1] == 0)
          abort_run("out_link vld before any flit was sent");
        if (cr_given <= rx_count)
          abort_run("out_link sent a flit without a credit");
        score_flit(out_link.flit);
        rx_count++;
        owed++;
        if (rx_count == stall_at)
          stall_left = $urandom_range(300, 100);
      end
      // credits held back during a stall
      if (stall_left > 0)
      begin
        stall_left--;
        out_cr <= 1'b0;
        if (stall_left == 0)
          check_count("out_link unused credits after stall", '0,
                      credit_width'(cr_given - rx_count));
      end
      else if (owed > 0 && $urandom_range(1) == 1)
      begin
        out_cr <= 1'b1;
        owed--;
        cr_given++;
      end
      else
        out_cr <= 1'b0;
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------

  initial
  begin
    void'($urandom(32'hd7e7_5328));
    reset    = 1'b1;
    in_link  = '0;
    out_cr   = 1'b0;
    cycle    = 0;
    cr_total = '{0, 0};
    sent     = '{0, 0};
    rx_count = 0;
    cr_given = 0;
    pkt_src  = 0;
    pkt_left = 0;
    last_src = -1;
    stall_at = $urandom_range(1000, 200);
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (in_cr !== 2'b00 || out_link.vld !== 1'b0)
      abort_run("link outputs not idle right after reset");
    fork
      run_receiver();
    join_none
    fork
      run_sender(0);
      run_sender(1);
    join
    while (exp_q0.size() + exp_q1.size() != 0)
      @(posedge clk);
    // FIFOs refill their credits one per cycle
    repeat (2 * fifo_depth + 4) @(posedge clk);
    check_count("in0_cr credits beyond flits sent", credit_width'(fifo_depth),
                credit_width'(cr_total[0] - sent[0]));
    check_count("in1_cr credits beyond flits sent", credit_width'(fifo_depth),
                credit_width'(cr_total[1] - sent[1]));
    if (dut.chk.fail_count == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      abort_run($sformatf("%0d assertion failures on the links", dut.chk.fail_count));
  end

endmodule

//--- verilog.f
rtl/credit_mux_pkg.sv
rtl/credit_rx_fifo.sv
rtl/packet_arbiter.sv
rtl/credit_tx.sv
rtl/credit_mux_top.sv
verification/credit_mux_assertions.sv
verification/tb_credit_mux.sv
